/* isaPkg.sv */
`default_nettype none

package isaPkg;

  typedef logic [31:0] word;   // data and byte address
  typedef logic [4:0]  regIdx; // x0..x31

  // major opcodes handled by the core, inst[6:0]
  typedef enum logic [6:0] {
    opcLoad   = 7'b0000011,
    opcStore  = 7'b0100011,
    opcBranch = 7'b1100011,
    opcJalr   = 7'b1100111,
    opcJal    = 7'b1101111,
    opcImm    = 7'b0010011, // reg-imm alu
    opcReg    = 7'b0110011, // reg-reg alu
    opcLui    = 7'b0110111,
    opcAuipc  = 7'b0010111,
    opcSystem = 7'b1110011  // only ebreak decoded
  } opcodeE;

  // immediate layout, R carries none
  typedef enum logic [2:0] {
    typeR = 3'd0,
    typeI = 3'd1,
    typeS = 3'd2,
    typeB = 3'd3,
    typeU = 3'd4,
    typeJ = 3'd5
  } instTypeE;

endpackage

`default_nettype wire

/* ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

  // alu op codes
  typedef enum logic [3:0] {
    aluAdd         = 4'd0,
    aluPassB       = 4'd1,  // lui
    aluAddClearLsb = 4'd2,  // jalr target
    aluSub         = 4'd3,
    aluSltu        = 4'd4,
    aluSlt         = 4'd5,
    aluXor         = 4'd6,
    aluSra         = 4'd7,
    aluOr          = 4'd8,
    aluAnd         = 4'd9,
    aluSll         = 4'd10,
    aluSrl         = 4'd11
  } aluOpE;

  typedef enum logic {aRs1 = 1'b0, aPc = 1'b1} aSelE;

  typedef enum logic [1:0] {bRs2 = 2'd0, bImm = 2'd1} bSelE;

  typedef enum logic [1:0] {wbMem = 2'd0, wbAlu = 2'd1, wbPc4 = 2'd2} wbSelE;

  // load extension, 0 means full word
  typedef enum logic [2:0] {
    extNone = 3'd0,
    extSb   = 3'd1,
    extSh   = 3'd2,
    extUb   = 3'd3,
    extUh   = 3'd4
  } memExtE;

  typedef enum logic [1:0] {sizeByte = 2'd0, sizeHalf = 2'd1, sizeWord = 2'd2} memSizeE;

  // all-zero bundle is a no-op
  typedef struct packed {
    logic     regWrite;
    logic     memRead;
    logic     memWrite;
    logic     ebreak;
    logic     pcSel;   // take aluResult as next pc
    logic     brUn;    // unsigned compare
    aSelE     aSel;
    bSelE     bSel;
    wbSelE    wbSel;
    aluOpE    aluOp;
    memExtE   memExt;
    memSizeE  memSize;
  } ctrlBundle;

endpackage

`default_nettype wire

/* instDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instDecoder (
  input  isaPkg::word        inst,
  input  logic               brEq,
  input  logic               brLt,
  output ctrlPkg::ctrlBundle ctrl,
  output isaPkg::instTypeE   instType
);

  isaPkg::opcodeE     opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  ctrlPkg::ctrlBundle opTab;  // keyed by opcode
  ctrlPkg::ctrlBundle f3Tab;  // opcode + funct3
  ctrlPkg::ctrlBundle f7Tab;  // opcode + funct3 + funct7
  logic               brTaken;

  assign opcode = isaPkg::opcodeE'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // alu result written to rd
  function automatic ctrlPkg::ctrlBundle aluCtrl(input ctrlPkg::aluOpE op,
                                                  input ctrlPkg::bSelE bSel);
    ctrlPkg::ctrlBundle c;
    c          = '0;
    c.regWrite = 1'b1;
    c.bSel     = bSel;
    c.wbSel    = ctrlPkg::wbAlu;
    c.aluOp    = op;
    return c;
  endfunction

  function automatic ctrlPkg::ctrlBundle memCtrl(input logic isStore,
                                                  input ctrlPkg::memExtE ext,
                                                  input ctrlPkg::memSizeE size);
    ctrlPkg::ctrlBundle c;
    c          = '0;
    c.regWrite = !isStore;
    c.memRead  = !isStore;
    c.memWrite = isStore;
    c.bSel     = ctrlPkg::bImm; // address is rs1 + imm
    c.wbSel    = ctrlPkg::wbMem;
    c.memExt   = ext;
    c.memSize  = size;
    return c;
  endfunction

  always_comb begin
    opTab = '0;
    case (opcode)
      isaPkg::opcLui:   opTab = aluCtrl(ctrlPkg::aluPassB, ctrlPkg::bImm);
      isaPkg::opcAuipc: begin
        opTab      = aluCtrl(ctrlPkg::aluAdd, ctrlPkg::bImm);
        opTab.aSel = ctrlPkg::aPc;
      end
      isaPkg::opcJal: begin
        opTab       = aluCtrl(ctrlPkg::aluAdd, ctrlPkg::bImm);
        opTab.aSel  = ctrlPkg::aPc;
        opTab.wbSel = ctrlPkg::wbPc4; // link
        opTab.pcSel = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin
    f3Tab = '0;
    case ({opcode, funct3})
      {isaPkg::opcSystem, 3'b000}: f3Tab.ebreak = 1'b1; // ecall not separated
      {isaPkg::opcJalr, 3'b000}: begin
        f3Tab       = aluCtrl(ctrlPkg::aluAddClearLsb, ctrlPkg::bImm);
        f3Tab.wbSel = ctrlPkg::wbPc4;
        f3Tab.pcSel = 1'b1;
      end
      {isaPkg::opcImm, 3'b000}: f3Tab = aluCtrl(ctrlPkg::aluAdd, ctrlPkg::bImm);
      {isaPkg::opcImm, 3'b010}: f3Tab = aluCtrl(ctrlPkg::aluSlt, ctrlPkg::bImm);
      {isaPkg::opcImm, 3'b011}: f3Tab = aluCtrl(ctrlPkg::aluSltu, ctrlPkg::bImm);
      {isaPkg::opcImm, 3'b100}: f3Tab = aluCtrl(ctrlPkg::aluXor, ctrlPkg::bImm);
      {isaPkg::opcImm, 3'b110}: f3Tab = aluCtrl(ctrlPkg::aluOr, ctrlPkg::bImm);
      {isaPkg::opcImm, 3'b111}: f3Tab = aluCtrl(ctrlPkg::aluAnd, ctrlPkg::bImm);
      {isaPkg::opcLoad, 3'b000}: f3Tab = memCtrl(1'b0, ctrlPkg::extSb, ctrlPkg::sizeByte);
      {isaPkg::opcLoad, 3'b001}: f3Tab = memCtrl(1'b0, ctrlPkg::extSh, ctrlPkg::sizeByte);
      {isaPkg::opcLoad, 3'b010}: f3Tab = memCtrl(1'b0, ctrlPkg::extNone, ctrlPkg::sizeByte);
      {isaPkg::opcLoad, 3'b100}: f3Tab = memCtrl(1'b0, ctrlPkg::extUb, ctrlPkg::sizeByte);
      {isaPkg::opcLoad, 3'b101}: f3Tab = memCtrl(1'b0, ctrlPkg::extUh, ctrlPkg::sizeByte);
      {isaPkg::opcStore, 3'b000}: f3Tab = memCtrl(1'b1, ctrlPkg::extNone, ctrlPkg::sizeByte);
      {isaPkg::opcStore, 3'b001}: f3Tab = memCtrl(1'b1, ctrlPkg::extNone, ctrlPkg::sizeHalf);
      {isaPkg::opcStore, 3'b010}: f3Tab = memCtrl(1'b1, ctrlPkg::extNone, ctrlPkg::sizeWord);
      {isaPkg::opcBranch, 3'b000}, {isaPkg::opcBranch, 3'b001},
      {isaPkg::opcBranch, 3'b100}, {isaPkg::opcBranch, 3'b101},
      {isaPkg::opcBranch, 3'b110}, {isaPkg::opcBranch, 3'b111}: begin
        f3Tab      = '0;
        f3Tab.aSel = ctrlPkg::aPc;  // target = pc + imm
        f3Tab.bSel = ctrlPkg::bImm;
        f3Tab.brUn = funct3[1];     // bltu, bgeu
      end
      default: ;
    endcase
  end

  always_comb begin
    f7Tab = '0;
    case ({opcode, funct3, funct7})
      {isaPkg::opcReg, 3'b000, 7'h00}: f7Tab = aluCtrl(ctrlPkg::aluAdd, ctrlPkg::bRs2);
      {isaPkg::opcReg, 3'b000, 7'h20}: f7Tab = aluCtrl(ctrlPkg::aluSub, ctrlPkg::bRs2);
      {isaPkg::opcReg, 3'b001, 7'h00}: f7Tab = aluCtrl(ctrlPkg::aluSll, ctrlPkg::bRs2);
      {isaPkg::opcReg, 3'b010, 7'h00}: f7Tab = aluCtrl(ctrlPkg::aluSlt, ctrlPkg::bRs2);
      {isaPkg::opcReg, 3'b011, 7'h00}: f7Tab = aluCtrl(ctrlPkg::aluSltu, ctrlPkg::bRs2);
      {isaPkg::opcReg, 3'b100, 7'h00}: f7Tab = aluCtrl(ctrlPkg::aluXor, ctrlPkg::bRs2);
      {isaPkg::opcReg, 3'b101, 7'h00}: f7Tab = aluCtrl(ctrlPkg::aluSrl, ctrlPkg::bRs2);
      {isaPkg::opcReg, 3'b101, 7'h20}: f7Tab = aluCtrl(ctrlPkg::aluSra, ctrlPkg::bRs2);
      {isaPkg::opcReg, 3'b110, 7'h00}: f7Tab = aluCtrl(ctrlPkg::aluOr, ctrlPkg::bRs2);
      {isaPkg::opcReg, 3'b111, 7'h00}: f7Tab = aluCtrl(ctrlPkg::aluAnd, ctrlPkg::bRs2);
      // immediate shifts, funct7 sits in the imm field
      {isaPkg::opcImm, 3'b001, 7'h00}: f7Tab = aluCtrl(ctrlPkg::aluSll, ctrlPkg::bImm);
      {isaPkg::opcImm, 3'b101, 7'h00}: f7Tab = aluCtrl(ctrlPkg::aluSrl, ctrlPkg::bImm);
      {isaPkg::opcImm, 3'b101, 7'h20}: f7Tab = aluCtrl(ctrlPkg::aluSra, ctrlPkg::bImm);
      default: ;
    endcase
  end

  // branch resolution from the comparator flags
  always_comb begin
    brTaken = 1'b0;
    if (opcode == isaPkg::opcBranch) begin
      case (funct3)
        3'b000:         brTaken = brEq;   // beq
        3'b001:         brTaken = !brEq;  // bne
        3'b100, 3'b110: brTaken = brLt;   // blt, bltu
        3'b101, 3'b111: brTaken = !brLt;  // bge, bgeu
        default:        brTaken = 1'b0;
      endcase
    end
  end

  // tables never overlap, so a plain OR merges them
  always_comb begin
    ctrl       = opTab | f3Tab | f7Tab;
    ctrl.pcSel = ctrl.pcSel | brTaken;
  end

  always_comb begin
    case (opcode)
      isaPkg::opcLui, isaPkg::opcAuipc: instType = isaPkg::typeU;
      isaPkg::opcJal:                   instType = isaPkg::typeJ;
      isaPkg::opcJalr, isaPkg::opcLoad,
      isaPkg::opcImm, isaPkg::opcSystem: instType = isaPkg::typeI;
      isaPkg::opcBranch:                instType = isaPkg::typeB;
      isaPkg::opcStore:                 instType = isaPkg::typeS;
      default:                          instType = isaPkg::typeR; // op and unknown
    endcase
  end

  // merged bundle must never request a read and a write at once
  always_comb begin
    assert final (!(ctrl.memRead && ctrl.memWrite))
      else $error("instDecoder: memRead and memWrite both set, inst %h", inst);
  end

endmodule

`default_nettype wire

/* immGen.sv */
`timescale 1ns/1ps
`default_nettype none

module immGen (
  input  isaPkg::word      inst,
  input  isaPkg::instTypeE instType,
  output isaPkg::word      imm
);

  logic sign;

  assign sign = inst[31]; // all formats keep the sign here

  always_comb begin
    case (instType)
      isaPkg::typeI: imm = {{20{sign}}, inst[31:20]};
      isaPkg::typeS: imm = {{20{sign}}, inst[31:25], inst[11:7]};
      // scrambled B and J fields, bit 0 always zero
      isaPkg::typeB: imm = {{19{sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};
      isaPkg::typeU: imm = {inst[31:12], 12'b0};
      isaPkg::typeJ: imm = {{11{sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};
      default:       imm = '0; // R type
    endcase
  end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic          clk,
  input  logic          arstN,
  input  isaPkg::regIdx rs1Idx,
  input  isaPkg::regIdx rs2Idx,
  input  isaPkg::regIdx rdIdx,
  input  logic          rdWe,
  input  isaPkg::word   rdData,
  output isaPkg::word   rs1Data,
  output isaPkg::word   rs2Data
);

  isaPkg::word regs [32];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rdWe && rdIdx != '0) begin // x0 stays zero
      regs[rdIdx] <= rdData;
    end
  end

  // async reads
  assign rs1Data = (rs1Idx == '0) ? '0 : regs[rs1Idx];
  assign rs2Data = (rs2Idx == '0) ? '0 : regs[rs2Idx];

endmodule

`default_nettype wire

/* execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit (
  input  ctrlPkg::ctrlBundle ctrl,
  input  isaPkg::word        rs1Data,
  input  isaPkg::word        rs2Data,
  input  isaPkg::word        pc,
  input  isaPkg::word        imm,
  output isaPkg::word        aluResult,
  output logic               brEq,
  output logic               brLt
);

  isaPkg::word opA;
  isaPkg::word opB;
  logic [4:0]  shamt;
  isaPkg::word sum;

  assign opA   = (ctrl.aSel == ctrlPkg::aPc) ? pc : rs1Data;
  assign opB   = (ctrl.bSel == ctrlPkg::bImm) ? imm : rs2Data;
  assign shamt = opB[4:0]; // srai funct7 bit above is ignored
  assign sum   = opA + opB;

  always_comb begin
    case (ctrl.aluOp)
      ctrlPkg::aluAdd:         aluResult = sum;
      ctrlPkg::aluPassB:       aluResult = opB;
      ctrlPkg::aluAddClearLsb: aluResult = {sum[31:1], 1'b0};
      ctrlPkg::aluSub:         aluResult = opA - opB;
      ctrlPkg::aluSltu:        aluResult = {31'b0, opA < opB};
      ctrlPkg::aluSlt:         aluResult = {31'b0, $signed(opA) < $signed(opB)};
      ctrlPkg::aluXor:         aluResult = opA ^ opB;
      ctrlPkg::aluSra:         aluResult = $unsigned($signed(opA) >>> shamt);
      ctrlPkg::aluOr:          aluResult = opA | opB;
      ctrlPkg::aluAnd:         aluResult = opA & opB;
      ctrlPkg::aluSll:         aluResult = opA << shamt;
      ctrlPkg::aluSrl:         aluResult = opA >> shamt;
      default:                 aluResult = '0;
    endcase
  end

  // comparator always sees the registers, not the alu operands
  assign brEq = (rs1Data == rs2Data);
  assign brLt = ctrl.brUn ? (rs1Data < rs2Data)
                          : ($signed(rs1Data) < $signed(rs2Data));

endmodule

`default_nettype wire

/* memAlign.sv */
`timescale 1ns/1ps
`default_nettype none

module memAlign (
  input  ctrlPkg::ctrlBundle ctrl,
  input  isaPkg::word        addr,
  input  isaPkg::word        storeData,
  input  isaPkg::word        memRdata,
  output isaPkg::word        memWdata,
  output logic [3:0]         memWmask,
  output isaPkg::word        loadData
);

  logic [1:0]  lane;
  logic [3:0]  sizeMask; // mask before lane shift
  isaPkg::word rdShift;  // addressed lane moved to bit 0
  logic        halfAcc;
  logic        wordAcc;

  assign lane = addr[1:0];

  // replicate so every lane carries the data
  always_comb begin
    case (ctrl.memSize)
      ctrlPkg::sizeByte: begin
        memWdata = {4{storeData[7:0]}};
        sizeMask = 4'b0001;
      end
      ctrlPkg::sizeHalf: begin
        memWdata = {2{storeData[15:0]}};
        sizeMask = 4'b0011;
      end
      ctrlPkg::sizeWord: begin
        memWdata = storeData;
        sizeMask = 4'b1111;
      end
      default: begin
        memWdata = storeData;
        sizeMask = 4'b0000;
      end
    endcase
  end

  assign memWmask = ctrl.memWrite ? (sizeMask << lane) : 4'b0000;

  assign rdShift = memRdata >> {lane, 3'b000};

  always_comb begin
    case (ctrl.memExt)
      ctrlPkg::extSb: loadData = {{24{rdShift[7]}}, rdShift[7:0]};
      ctrlPkg::extSh: loadData = {{16{rdShift[15]}}, rdShift[15:0]};
      ctrlPkg::extUb: loadData = {24'b0, rdShift[7:0]};
      ctrlPkg::extUh: loadData = {16'b0, rdShift[15:0]};
      default:        loadData = memRdata; // lw
    endcase
  end

  // natural alignment, no misaligned trap in this core
  assign halfAcc = (ctrl.memWrite && ctrl.memSize == ctrlPkg::sizeHalf)
                || (ctrl.memRead && (ctrl.memExt == ctrlPkg::extSh
                                  || ctrl.memExt == ctrlPkg::extUh));
  assign wordAcc = (ctrl.memWrite && ctrl.memSize == ctrlPkg::sizeWord)
                || (ctrl.memRead && ctrl.memExt == ctrlPkg::extNone);

  always_comb begin
    assert final (!(halfAcc && lane[0]) && !(wordAcc && lane != 2'b00))
      else $error("memAlign: misaligned access at %h", addr);
  end

endmodule

`default_nettype wire

/* commitUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module commitUnit #(
  parameter isaPkg::word resetPc = '0
) (
  input  logic               clk,
  input  logic               arstN,
  input  ctrlPkg::ctrlBundle ctrl,
  input  isaPkg::word        aluResult,
  input  isaPkg::word        loadData,
  output isaPkg::word        pc,
  output isaPkg::word        wbData,
  output logic               regWe,
  output logic               halted
);

  isaPkg::word pcPlus4;
  isaPkg::word nextPc;

  assign pcPlus4 = pc + 32'd4;
  assign nextPc  = ctrl.pcSel ? aluResult : pcPlus4; // jumps and taken branches

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc     <= resetPc;
      halted <= 1'b0;
    end else if (!halted) begin
      if (ctrl.ebreak) begin
        halted <= 1'b1; // pc parks on the ebreak
      end else begin
        pc <= nextPc;
      end
    end
  end

  always_comb begin
    case (ctrl.wbSel)
      ctrlPkg::wbMem: wbData = loadData;
      ctrlPkg::wbAlu: wbData = aluResult;
      ctrlPkg::wbPc4: wbData = pcPlus4;  // link address
      default:        wbData = aluResult;
    endcase
  end

  assign regWe = ctrl.regWrite && !halted;

  // halt is sticky and freezes fetch
  assert property (@(posedge clk) disable iff (!arstN)
                   halted |=> halted && $stable(pc))
    else $error("commitUnit: pc or halt changed while halted, pc %h", pc);

endmodule

`default_nettype wire

/* rvCore.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCore #(
  parameter isaPkg::word resetPc = '0
) (
  input  logic        clk,
  input  logic        arstN,
  output isaPkg::word pc,
  input  isaPkg::word inst,
  output isaPkg::word memAddr,
  output isaPkg::word memWdata,
  output logic [3:0]  memWmask,
  output logic        memRead,
  output logic        memWrite,
  input  isaPkg::word memRdata,
  output logic        halted
);

  ctrlPkg::ctrlBundle ctrl;
  isaPkg::instTypeE   instType;
  isaPkg::regIdx      rs1Idx;
  isaPkg::regIdx      rs2Idx;
  isaPkg::regIdx      rdIdx;
  isaPkg::word        imm;
  isaPkg::word        rs1Data;
  isaPkg::word        rs2Data;
  isaPkg::word        aluResult;
  isaPkg::word        loadData;
  isaPkg::word        wbData;
  logic               brEq;
  logic               brLt;
  logic               regWe;

  assign rs1Idx = inst[19:15];
  assign rs2Idx = inst[24:20];
  assign rdIdx  = inst[11:7];

  instDecoder uDec (.inst(inst), .brEq(brEq), .brLt(brLt),
                    .ctrl(ctrl), .instType(instType));

  immGen uImm (.inst(inst), .instType(instType), .imm(imm));

  regFile uRf (
    .clk(clk), .arstN(arstN),
    .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rdIdx(rdIdx),
    .rdWe(regWe), .rdData(wbData),
    .rs1Data(rs1Data), .rs2Data(rs2Data)
  );

  execUnit uExec (
    .ctrl(ctrl), .rs1Data(rs1Data), .rs2Data(rs2Data), .pc(pc), .imm(imm),
    .aluResult(aluResult), .brEq(brEq), .brLt(brLt)
  );

  // low address bits kept, memory ignores them for word select
  memAlign uAlign (
    .ctrl(ctrl), .addr(aluResult), .storeData(rs2Data), .memRdata(memRdata),
    .memWdata(memWdata), .memWmask(memWmask), .loadData(loadData)
  );

  commitUnit #(.resetPc(resetPc)) uCommit (
    .clk(clk), .arstN(arstN), .ctrl(ctrl),
    .aluResult(aluResult), .loadData(loadData),
    .pc(pc), .wbData(wbData), .regWe(regWe), .halted(halted)
  );

  assign memAddr  = aluResult;
  assign memRead  = ctrl.memRead && !halted;  // quiet bus once halted
  assign memWrite = ctrl.memWrite && !halted;

endmodule

`default_nettype wire

/* tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
  parameter int periodNs    = 8,
  parameter int resetCycles = 8
) (
  output logic clk,
  output logic arstN
);

  initial clk = 1'b0;
  always #(periodNs / 2) clk = ~clk; // free running

  initial begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1; // release away from the active edge
  end

endmodule

`default_nettype wire

/* tbRvCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tbRvCore;

  logic        clk;
  logic        arstN;
  isaPkg::word pc;
  isaPkg::word inst;
  isaPkg::word memAddr;
  isaPkg::word memWdata;
  logic [3:0]  memWmask;
  logic        memRead;
  logic        memWrite;
  isaPkg::word memRdata;
  logic        halted;

  isaPkg::word imem [1024];
  isaPkg::word dmem [512];    // dut side data memory
  isaPkg::word sMem [512];    // shadow copy
  isaPkg::word sRegs [32];
  isaPkg::word sPc;
  logic        sHalted;
  int          progLen;
  int          commitCount;
  int          stepCount;

  // expected port values for the instruction at sPc
  isaPkg::word expPc;
  isaPkg::word expAddr;
  isaPkg::word expWdata;
  logic [3:0]  expMask;
  logic        expMemRead;
  logic        expMemWrite;
  logic        expHalted;

  // effects applied when that instruction commits
  isaPkg::word pNextPc;
  isaPkg::word pRdVal;
  int          pRd;
  int          pMemIdx;
  logic        pHalt;

  tbClock #(.periodNs(8), .resetCycles(8)) clkGen (.clk(clk), .arstN(arstN));

  rvCore #(.resetPc(32'h0)) dut0 (
    .clk(clk), .arstN(arstN), .pc(pc), .inst(inst),
    .memAddr(memAddr), .memWdata(memWdata), .memWmask(memWmask),
    .memRead(memRead), .memWrite(memWrite), .memRdata(memRdata), .halted(halted)
  );

  assign inst     = arstN ? imem[pc[11:2]] : '0; // zero word during reset
  assign memRdata = dmem[memAddr[10:2]];

  always @(posedge clk) begin
    if (arstN && memWrite) begin
      for (int b = 0; b < 4; b++) begin
        if (memWmask[b]) dmem[memAddr[10:2]][b*8 +: 8] <= memWdata[b*8 +: 8];
      end
    end
    if (arstN) commitCount <= commitCount + 1;
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  function automatic isaPkg::word encI(input int imm, input int rs1, input int f3,
                                       input int rd, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic isaPkg::word encS(input int imm, input int rs2, input int f3);
    return {imm[11:5], rs2[4:0], 5'd0, f3[2:0], imm[4:0], 7'h23}; // base is x0
  endfunction

  function automatic isaPkg::word encB(input int imm, input int rs2, input int rs1,
                                       input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic isaPkg::word encJ(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  function automatic isaPkg::word aluRef(input logic [2:0] f3, input logic alt,
                                         input isaPkg::word a, input isaPkg::word b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic emit(input isaPkg::word w);
    imem[progLen] = w;
    progLen++;
  endtask

  task automatic storeBack(input int rs2); // sw rs2 at a random word slot
    emit(encS(($urandom % 128) * 4, rs2, 2));
  endtask

  // derive expectations and pending effects from the shadow state
  task automatic evalShadow();
    isaPkg::word w;
    isaPkg::word a;
    isaPkg::word b;
    isaPkg::word immI;
    isaPkg::word addr;
    isaPkg::word rdW;
    logic [2:0]  f3;
    logic        take;
    w = imem[sPc[11:2]];
    a = sRegs[w[19:15]];
    b = sRegs[w[24:20]];
    f3 = w[14:12];
    immI = {{20{w[31]}}, w[31:20]};
    expPc = sPc;
    expHalted = sHalted;
    expMemRead = 1'b0;
    expMemWrite = 1'b0;
    expMask = 4'b0;
    expAddr = '0;
    expWdata = '0;
    pNextPc = sPc + 4;
    pRd = 0;
    pRdVal = '0;
    pMemIdx = -1;
    pHalt = 1'b0;
    if (sHalted) begin
      pNextPc = sPc;
    end else begin
      case (w[6:0])
        7'h37: begin pRd = w[11:7]; pRdVal = {w[31:12], 12'b0}; end
        7'h17: begin pRd = w[11:7]; pRdVal = sPc + {w[31:12], 12'b0}; end
        7'h6f: begin
          pRd = w[11:7];
          pRdVal = sPc + 4;
          pNextPc = sPc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        7'h67: begin
          pRd = w[11:7];
          pRdVal = sPc + 4;
          pNextPc = (a + immI) & ~32'd1; // target lsb dropped
        end
        7'h63: begin
          case (f3)
            3'd0:    take = a == b;
            3'd1:    take = a != b;
            3'd4:    take = $signed(a) < $signed(b);
            3'd5:    take = $signed(a) >= $signed(b);
            3'd6:    take = a < b;
            default: take = a >= b;
          endcase
          if (take) pNextPc = sPc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
        7'h03: begin
          addr = a + immI;
          expMemRead = 1'b1;
          rdW = sMem[addr[10:2]] >> (8 * addr[1:0]);
          pRd = w[11:7];
          case (f3)
            3'd0:    pRdVal = {{24{rdW[7]}}, rdW[7:0]};
            3'd1:    pRdVal = {{16{rdW[15]}}, rdW[15:0]};
            3'd4:    pRdVal = {24'b0, rdW[7:0]};
            3'd5:    pRdVal = {16'b0, rdW[15:0]};
            default: pRdVal = sMem[addr[10:2]];
          endcase
        end
        7'h23: begin
          addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
          expMemWrite = 1'b1;
          expAddr = addr;
          case (f3)
            3'd0: begin expWdata = {4{b[7:0]}}; expMask = 4'b0001 << addr[1:0]; end
            3'd1: begin expWdata = {2{b[15:0]}}; expMask = 4'b0011 << addr[1:0]; end
            default: begin expWdata = b; expMask = 4'b1111; end
          endcase
          pMemIdx = addr[10:2];
        end
        7'h13: begin
          pRd = w[11:7];
          pRdVal = aluRef(f3, f3 == 3'd5 && w[30], a, immI); // only srai uses bit 30
        end
        7'h33: begin pRd = w[11:7]; pRdVal = aluRef(f3, w[30], a, b); end
        7'h73: begin pHalt = 1'b1; pNextPc = sPc; end
        default: ;
      endcase
    end
  endtask

  task automatic commitShadow();
    if (pRd != 0) sRegs[pRd] = pRdVal;
    if (pMemIdx >= 0) begin
      for (int k = 0; k < 4; k++) begin
        if (expMask[k]) sMem[pMemIdx][k*8 +: 8] = expWdata[k*8 +: 8];
      end
    end
    sPc = pNextPc;
    if (pHalt) sHalted = 1'b1;
  endtask

  always @(negedge clk) begin
    if (commitCount != stepCount) begin
      commitShadow();
      evalShadow();
      stepCount++;
    end
  end

  initial begin
    int kind;
    int rd;
    int f3;
    int sz;
    int rs1;
    int imm;
    int lds [5];
    void'($urandom(32'h0a84_b20a));
    lds = '{0, 1, 2, 4, 5};
    progLen = 0;
    stepCount = 0;
    for (int i = 0; i < 1024; i++) imem[i] = '0;
    for (int i = 0; i < 512; i++) begin
      sMem[i] = (i * 32'h9e37_79b9) ^ {i[15:0], ~i[15:0]}; // every address bit matters
      dmem[i] <= sMem[i];
    end
    for (int i = 0; i < 32; i++) sRegs[i] = '0;
    sPc = '0;
    sHalted = 1'b0;
    // x31 = -1 orders differently signed and unsigned against x0
    emit(encI(-1, 0, 0, 31, 7'h13));
    for (int k = 0; k < 6; k++) begin
      f3 = (k < 2) ? k : k + 2; // beq bne blt bge bltu bgeu
      for (int p = 0; p < 3; p++) begin
        emit(encB(8, (p == 1) ? 0 : 31, (p == 2) ? 0 : 31, f3));
        emit(encI($urandom, 1, 0, 1, 7'h13)); // filler
      end
    end
    for (int blk = 0; blk < 60; blk++) begin
      kind = $urandom % 7;
      rd = 1 + $urandom % 15;
      rs1 = 1 + $urandom % 15;
      case (kind)
        0: begin // lui plus addi constant
          emit({20'($urandom), 5'(rd), 7'h37});
          emit(encI($urandom, rd, 0, rd, 7'h13));
        end
        1: begin
          f3 = $urandom % 8;
          emit({((f3 == 0 || f3 == 5) && $urandom % 2 == 1) ? 7'h20 : 7'h00,
                5'(1 + $urandom % 15), 5'(rs1), 3'(f3), 5'(rd), 7'h33});
          storeBack(rd);
        end
        2: begin
          f3 = $urandom % 8;
          imm = $urandom;
          if (f3 == 1) imm = $urandom % 32;
          if (f3 == 5) imm = ($urandom % 32) | (($urandom % 2) << 10); // srli or srai
          emit(encI(imm, rs1, f3, rd, 7'h13));
          storeBack(rd);
        end
        3: begin
          sz = $urandom % 3;
          emit(encS(($urandom % 512) & ~((1 << sz) - 1), rs1, sz));
        end
        4: begin // load any width, then store it back
          f3 = lds[$urandom % 5];
          emit(encI(($urandom % 512) & ~((1 << (f3 % 4)) - 1), 0, f3, rd, 7'h03));
          storeBack(rd);
        end
        5: begin // branch over one filler
          f3 = lds[$urandom % 5];
          if (f3 == 2) f3 = 6; // funct3 010 is no branch
          if ($urandom % 6 == 0) f3 = 7;
          emit(encB(8, ($urandom % 4 == 0) ? rs1 : 1 + $urandom % 15, rs1, f3));
          emit(encI($urandom, rd, 0, rd, 7'h13));
        end
        default: begin
          if ($urandom % 2 == 1) begin
            emit(encJ(8, rd));
          end else begin
            emit({20'b0, 5'd30, 7'h17});         // auipc x30, 0
            emit(encI(13, 30, 0, rd, 7'h67));    // odd offset, lsb cleared
          end
          emit(encI($urandom, rd, 0, rd, 7'h13));
          storeBack(rd);
        end
      endcase
    end
    emit(32'h0010_0073); // ebreak
    evalShadow();
    #(progLen * 8 + 16 * 8 + 200);
    abortRun("core did not halt before the watchdog expired");
  end

  initial begin
    wait (arstN);
    @(posedge halted);
    repeat (5) @(negedge clk); // hold checks run meanwhile
    $display("Test passed");
    $finish;
  end

  // fetch sees a zero word while reset is held
  assert property (@(posedge clk) !arstN |-> pc == 32'h0 && !halted && !memRead && !memWrite)
    else abortRun($sformatf(
      "ERROR at %0t: reset state got pc %h halted %b memRead %b memWrite %b expected 0 0 0 0",
      $time, $sampled(pc), $sampled(halted), $sampled(memRead), $sampled(memWrite)));
  assert property (@(posedge clk) disable iff (!arstN) pc == expPc)
    else abortRun($sformatf("ERROR at %0t: pc got %h expected %h", $time, $sampled(pc), expPc));
  assert property (@(posedge clk) disable iff (!arstN) halted == expHalted)
    else abortRun($sformatf("ERROR at %0t: halted got %b expected %b",
                            $time, $sampled(halted), expHalted));
  assert property (@(posedge clk) disable iff (!arstN) memRead == expMemRead)
    else abortRun($sformatf("ERROR at %0t: memRead got %b expected %b",
                            $time, $sampled(memRead), expMemRead));
  assert property (@(posedge clk) disable iff (!arstN) memWrite == expMemWrite)
    else abortRun($sformatf("ERROR at %0t: memWrite got %b expected %b",
                            $time, $sampled(memWrite), expMemWrite));
  assert property (@(posedge clk) disable iff (!arstN) memWmask == expMask)
    else abortRun($sformatf("ERROR at %0t: memWmask got %b expected %b",
                            $time, $sampled(memWmask), expMask));
  assert property (@(posedge clk) disable iff (!arstN) memWrite |-> memAddr == expAddr)
    else abortRun($sformatf("ERROR at %0t: memAddr got %h expected %h",
                            $time, $sampled(memAddr), expAddr));
  assert property (@(posedge clk) disable iff (!arstN) memWrite |-> memWdata == expWdata)
    else abortRun($sformatf("ERROR at %0t: memWdata got %h expected %h",
                            $time, $sampled(memWdata), expWdata));
  // once halted the core stays frozen and quiet
  assert property (@(posedge clk) disable iff (!arstN)
                   halted |=> halted && $stable(pc) && !memWrite && !memRead)
    else abortRun("core left the halted state or touched memory after halting");

endmodule

`default_nettype wire

/* compile.f */
isaPkg.sv
ctrlPkg.sv
instDecoder.sv
immGen.sv
regFile.sv
execUnit.sv
memAlign.sv
commitUnit.sv
rvCore.sv
tbClock.sv
tbRvCore.sv

/* run.sh */
#!/bin/sh
# build and run the rvCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbRvCore -f compile.f -o simRvCore
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/simRvCore
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0
